// File: hdl/alu.sv
// 32-bit integer ALU
// add/sub, logic, shifts and compares for RV32I

`timescale 1ns/1ps

module alu (
  input  rv_constants_pkg::alu_func_t alu_function,
  input  logic [31:0]                 operand_a,
  input  logic [31:0]                 operand_b,
  output logic [31:0]                 alu_result
);

  logic [4:0] shamt;

  // shift amount from the low five bits only
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      rv_constants_pkg::ALU_ADD: begin
        alu_result = operand_a + operand_b;
      end
      rv_constants_pkg::ALU_SUB: begin
        alu_result = operand_a - operand_b;
      end
      rv_constants_pkg::ALU_SLL: begin
        alu_result = operand_a << shamt;
      end
      rv_constants_pkg::ALU_SRL: begin
        alu_result = operand_a >> shamt;
      end
      rv_constants_pkg::ALU_SRA: begin
        alu_result = $unsigned($signed(operand_a) >>> shamt);
      end
      rv_constants_pkg::ALU_XOR: begin
        alu_result = operand_a ^ operand_b;
      end
      rv_constants_pkg::ALU_OR: begin
        alu_result = operand_a | operand_b;
      end
      rv_constants_pkg::ALU_AND: begin
        alu_result = operand_a & operand_b;
      end
      // compares produce 0 or 1
      rv_constants_pkg::ALU_SLT: begin
        alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      end
      rv_constants_pkg::ALU_SLTU: begin
        alu_result = {31'b0, operand_a < operand_b};
      end
      rv_constants_pkg::ALU_SEQ: begin
        alu_result = {31'b0, operand_a == operand_b};
      end
      default: begin
        alu_result = 32'b0;
      end
    endcase
  end

endmodule

// File: hdl/alu_control.sv
// ALU controller
// picks the ALU function from control class, funct3 and funct7

`timescale 1ns/1ps

module alu_control (
  input  rv_constants_pkg::alu_class_t alu_op_type,
  input  logic [2:0]                   inst_funct3,
  input  logic [6:0]                   inst_funct7,
  output rv_constants_pkg::alu_func_t  alu_function
);

  rv_constants_pkg::alu_func_t default_funct;
  rv_constants_pkg::alu_func_t secondary_funct;
  rv_constants_pkg::alu_func_t op_funct;
  rv_constants_pkg::alu_func_t op_imm_funct;
  rv_constants_pkg::alu_func_t branch_funct;

  always_comb begin
    case (inst_funct3)
      rv_constants_pkg::FUNCT3_ALU_ADD_SUB: default_funct = rv_constants_pkg::ALU_ADD;
      rv_constants_pkg::FUNCT3_ALU_SLL:     default_funct = rv_constants_pkg::ALU_SLL;
      rv_constants_pkg::FUNCT3_ALU_SLT:     default_funct = rv_constants_pkg::ALU_SLT;
      rv_constants_pkg::FUNCT3_ALU_SLTU:    default_funct = rv_constants_pkg::ALU_SLTU;
      rv_constants_pkg::FUNCT3_ALU_XOR:     default_funct = rv_constants_pkg::ALU_XOR;
      rv_constants_pkg::FUNCT3_ALU_SHIFTR:  default_funct = rv_constants_pkg::ALU_SRL;
      rv_constants_pkg::FUNCT3_ALU_OR:      default_funct = rv_constants_pkg::ALU_OR;
      default:                              default_funct = rv_constants_pkg::ALU_AND;
    endcase

    // funct7[5] variants, anything else is flagged illegal by decode
    case (inst_funct3)
      rv_constants_pkg::FUNCT3_ALU_ADD_SUB: secondary_funct = rv_constants_pkg::ALU_SUB;
      rv_constants_pkg::FUNCT3_ALU_SHIFTR:  secondary_funct = rv_constants_pkg::ALU_SRA;
      default:                              secondary_funct = rv_constants_pkg::ALU_ADD;
    endcase

    op_funct = inst_funct7[5] ? secondary_funct : default_funct;

    // in OP_IMM the upper bits are immediate except for shifts
    if (inst_funct7[5] && (inst_funct3[1:0] == 2'b01)) begin
      op_imm_funct = secondary_funct;
    end else begin
      op_imm_funct = default_funct;
    end

    case (inst_funct3)
      rv_constants_pkg::FUNCT3_BRANCH_EQ,
      rv_constants_pkg::FUNCT3_BRANCH_NE:  branch_funct = rv_constants_pkg::ALU_SEQ;
      rv_constants_pkg::FUNCT3_BRANCH_LT,
      rv_constants_pkg::FUNCT3_BRANCH_GE:  branch_funct = rv_constants_pkg::ALU_SLT;
      rv_constants_pkg::FUNCT3_BRANCH_LTU,
      rv_constants_pkg::FUNCT3_BRANCH_GEU: branch_funct = rv_constants_pkg::ALU_SLTU;
      default:                             branch_funct = rv_constants_pkg::ALU_ADD;
    endcase

    case (alu_op_type)
      rv_constants_pkg::CTL_ALU_OP:     alu_function = op_funct;
      rv_constants_pkg::CTL_ALU_OP_IMM: alu_function = op_imm_funct;
      rv_constants_pkg::CTL_ALU_BRANCH: alu_function = branch_funct;
      default:                          alu_function = rv_constants_pkg::ALU_ADD;
    endcase
  end

endmodule

// File: hdl/exec_regs.sv
// Wishbone classic slave for the execute unit
// instruction, operand and pc registers plus result read-back

`timescale 1ns/1ps

module exec_regs (
  input  logic        clk,
  input  logic        rst_n,
  // Wishbone classic slave
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [4:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  // results from the datapath
  input  logic [31:0] alu_result,
  input  logic [31:0] next_pc,
  input  logic        branch_taken,
  input  logic        illegal,
  // operands to the datapath
  output logic [31:0] instr,
  output logic [31:0] rs1_value,
  output logic [31:0] rs2_value,
  output logic [31:0] pc
);

  logic        req;
  logic [31:0] status_word;
  logic [31:0] rd_data;

  // new request only while ack is low, so each strobe gets one ack
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_comb begin
    status_word = 32'b0;
    status_word[exec_regs_pkg::STATUS_BRANCH_TAKEN] = branch_taken;
    status_word[exec_regs_pkg::STATUS_ILLEGAL]      = illegal;
  end

  // read mux, unmapped offsets give zero
  always_comb begin
    case (wb_adr)
      exec_regs_pkg::REG_INSTR:   rd_data = instr;
      exec_regs_pkg::REG_RS1:     rd_data = rs1_value;
      exec_regs_pkg::REG_RS2:     rd_data = rs2_value;
      exec_regs_pkg::REG_PC:      rd_data = pc;
      exec_regs_pkg::REG_RESULT:  rd_data = alu_result;
      exec_regs_pkg::REG_NEXT_PC: rd_data = next_pc;
      exec_regs_pkg::REG_STATUS:  rd_data = status_word;
      default:                    rd_data = 32'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      wb_dat_r  <= 32'b0;
      instr     <= 32'b0;
      rs1_value <= 32'b0;
      rs2_value <= 32'b0;
      pc        <= 32'b0;
    end else begin
      wb_ack <= req;
      if (req && wb_we) begin
        // read-only and unmapped writes are dropped
        case (wb_adr)
          exec_regs_pkg::REG_INSTR: instr     <= wb_dat_w;
          exec_regs_pkg::REG_RS1:   rs1_value <= wb_dat_w;
          exec_regs_pkg::REG_RS2:   rs2_value <= wb_dat_w;
          exec_regs_pkg::REG_PC:    pc        <= wb_dat_w;
          default: begin
          end
        endcase
      end
      if (req && !wb_we) begin
        wb_dat_r <= rd_data;
      end
    end
  end

endmodule

// File: hdl/exec_regs_pkg.sv
// register map of the execute unit Wishbone slave
// byte offsets and status word bit positions

package exec_regs_pkg;

  // host loaded registers
  localparam logic [4:0] REG_INSTR   = 5'h00;
  localparam logic [4:0] REG_RS1     = 5'h04;
  localparam logic [4:0] REG_RS2     = 5'h08;
  localparam logic [4:0] REG_PC      = 5'h0C;

  // results, read only
  localparam logic [4:0] REG_RESULT  = 5'h10;
  localparam logic [4:0] REG_NEXT_PC = 5'h14;
  localparam logic [4:0] REG_STATUS  = 5'h18;

  // status word bits
  localparam int STATUS_BRANCH_TAKEN = 0;
  localparam int STATUS_ILLEGAL      = 1;

endpackage

// File: hdl/exec_unit.sv
// top level of the RV32I execute unit
// register block feeding decode, ALU controller and ALU

`timescale 1ns/1ps

module exec_unit (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [4:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic [31:0]                  instr;
  logic [31:0]                  rs1_value;
  logic [31:0]                  rs2_value;
  logic [31:0]                  pc;
  logic [31:0]                  alu_result;
  logic [31:0]                  next_pc;
  logic                         branch_taken;
  logic                         illegal;
  logic [31:0]                  operand_a;
  logic [31:0]                  operand_b;
  rv_constants_pkg::alu_class_t alu_op_type;
  rv_constants_pkg::alu_func_t  alu_function;

  exec_regs i_exec_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .alu_result   (alu_result),
    .next_pc      (next_pc),
    .branch_taken (branch_taken),
    .illegal      (illegal),
    .instr        (instr),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .pc           (pc)
  );

  instr_decode i_instr_decode (
    .instr        (instr),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .pc           (pc),
    .alu_result   (alu_result),
    .alu_op_type  (alu_op_type),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .next_pc      (next_pc),
    .branch_taken (branch_taken),
    .illegal      (illegal)
  );

  // funct fields straight from the instruction word
  alu_control i_alu_control (
    .alu_op_type  (alu_op_type),
    .inst_funct3  (instr[14:12]),
    .inst_funct7  (instr[31:25]),
    .alu_function (alu_function)
  );

  alu i_alu (
    .alu_function (alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .alu_result   (alu_result)
  );

endmodule

// File: hdl/instr_decode.sv
// instruction decode for the execute unit
// opcode class, immediates, operand muxes, branch resolution, next pc

`timescale 1ns/1ps

module instr_decode (
  input  logic [31:0]                instr,
  input  logic [31:0]                rs1_value,
  input  logic [31:0]                rs2_value,
  input  logic [31:0]                pc,
  input  logic [31:0]                alu_result,
  output rv_constants_pkg::alu_class_t alu_op_type,
  output logic [31:0]                operand_a,
  output logic [31:0]                operand_b,
  output logic [31:0]                next_pc,
  output logic                       branch_taken,
  output logic                       illegal
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic        is_branch;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    alu_op_type = rv_constants_pkg::CTL_ALU_ADD;
    operand_a   = rs1_value;
    operand_b   = imm_i;
    is_branch   = 1'b0;
    illegal     = 1'b0;

    case (opcode)
      rv_constants_pkg::OPCODE_OP: begin
        alu_op_type = rv_constants_pkg::CTL_ALU_OP;
        operand_b   = rs2_value;
        // only SUB and SRA accept funct7 = 0x20
        if (funct7 == 7'h20) begin
          illegal = (funct3 != rv_constants_pkg::FUNCT3_ALU_ADD_SUB) &&
                    (funct3 != rv_constants_pkg::FUNCT3_ALU_SHIFTR);
        end else begin
          illegal = (funct7 != 7'h00);
        end
      end
      rv_constants_pkg::OPCODE_OP_IMM: begin
        alu_op_type = rv_constants_pkg::CTL_ALU_OP_IMM;
        // shamt is 5 bits, the rest of the upper field is fixed
        if (funct3 == rv_constants_pkg::FUNCT3_ALU_SLL) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == rv_constants_pkg::FUNCT3_ALU_SHIFTR) begin
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end
      rv_constants_pkg::OPCODE_LUI: begin
        operand_a = 32'b0;
        operand_b = imm_u;
      end
      rv_constants_pkg::OPCODE_AUIPC: begin
        operand_a = pc;
        operand_b = imm_u;
      end
      rv_constants_pkg::OPCODE_LOAD: begin
        operand_b = imm_i;
      end
      rv_constants_pkg::OPCODE_STORE: begin
        operand_b = imm_s;
      end
      rv_constants_pkg::OPCODE_BRANCH: begin
        alu_op_type = rv_constants_pkg::CTL_ALU_BRANCH;
        operand_b   = rs2_value;
        is_branch   = 1'b1;
        illegal     = (funct3[2:1] == 2'b01);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // compare result in bit 0, NE/GE/GEU invert it
  // a reserved branch encoding never redirects
  assign branch_taken = is_branch && !illegal && (alu_result[0] ^ funct3[0]);

  assign next_pc = branch_taken ? pc + imm_b : pc + 32'd4;

endmodule

// File: hdl/rv_constants_pkg.sv
// RV32I encodings used by the execute unit
// major opcodes, funct3 codes, ALU control classes and ALU function codes

package rv_constants_pkg;

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] FUNCT3_ALU_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_ALU_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_ALU_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_ALU_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_ALU_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_ALU_SHIFTR  = 3'b101;
  localparam logic [2:0] FUNCT3_ALU_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_ALU_AND     = 3'b111;

  // funct3 for conditional branches
  // bit 0 set means the inverted condition
  localparam logic [2:0] FUNCT3_BRANCH_EQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BRANCH_NE  = 3'b001;
  localparam logic [2:0] FUNCT3_BRANCH_LT  = 3'b100;
  localparam logic [2:0] FUNCT3_BRANCH_GE  = 3'b101;
  localparam logic [2:0] FUNCT3_BRANCH_LTU = 3'b110;
  localparam logic [2:0] FUNCT3_BRANCH_GEU = 3'b111;

  // class handed from decode to the ALU controller
  typedef enum logic [1:0] {
    CTL_ALU_ADD    = 2'b00,
    CTL_ALU_OP     = 2'b01,
    CTL_ALU_OP_IMM = 2'b10,
    CTL_ALU_BRANCH = 2'b11
  } alu_class_t;

  // operation selected inside the ALU
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b00001,
    ALU_SLL  = 5'b00010,
    ALU_SLT  = 5'b00011,
    ALU_SLTU = 5'b00100,
    ALU_XOR  = 5'b00101,
    ALU_SRL  = 5'b00110,
    ALU_SRA  = 5'b00111,
    ALU_OR   = 5'b01000,
    ALU_AND  = 5'b01001,
    ALU_SEQ  = 5'b01010
  } alu_func_t;

endpackage

// File: list.f
+incdir+tb
hdl/rv_constants_pkg.sv
hdl/exec_regs_pkg.sv
hdl/instr_decode.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/exec_regs.sv
hdl/exec_unit.sv
tb/tb_exec_unit.sv

// File: run.sh
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_exec_unit \
  -Mdir obj_dir -o sim_exec_unit

# keep going after a failing run so the log decides
./obj_dir/sim_exec_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: tb/exec_model.svh
// reference model of the RV32I execute unit
// ALU function helper and exec_ref returning {result, next pc, status}

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// one ALU operation by funct3, alt selects SUB or SRA
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'b000: r = alt ? a - b : a + b;
    3'b001: r = a << b[4:0];
    3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: r = (a < b) ? 32'd1 : 32'd0;
    3'b100: r = a ^ b;
    3'b101: r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic logic [95:0] exec_ref(input logic [31:0] instr, input logic [31:0] rs1,
                                         input logic [31:0] rs2, input logic [31:0] pc);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] res;
  logic [31:0] npc;
  logic [31:0] status;
  logic        taken;
  logic        bad;
  opc   = instr[6:0];
  f3    = instr[14:12];
  f7    = instr[31:25];
  imm_i = {{20{instr[31]}}, instr[31:20]};
  imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_u = {instr[31:12], 12'b0};
  res   = 32'b0;
  taken = 1'b0;
  bad   = 1'b0;
  case (opc)
    rv_constants_pkg::OPCODE_OP: begin
      res = alu_ref(f3, f7[5], rs1, rs2);
      bad = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)));
    end
    rv_constants_pkg::OPCODE_OP_IMM: begin
      // only shifts read funct7, srai needs 0x20
      res = alu_ref(f3, (f3 == 3'b101) && f7[5], rs1, imm_i);
      if (f3 == 3'b001)
        bad = (f7 != 7'h00);
      else if (f3 == 3'b101)
        bad = (f7 != 7'h00) && (f7 != 7'h20);
    end
    rv_constants_pkg::OPCODE_LUI:   res = imm_u;
    rv_constants_pkg::OPCODE_AUIPC: res = pc + imm_u;
    rv_constants_pkg::OPCODE_LOAD:  res = rs1 + imm_i;
    rv_constants_pkg::OPCODE_STORE: res = rs1 + imm_s;
    rv_constants_pkg::OPCODE_BRANCH: begin
      case (f3)
        3'b000, 3'b001: res = (rs1 == rs2) ? 32'd1 : 32'd0;
        3'b100, 3'b101: res = ($signed(rs1) < $signed(rs2)) ? 32'd1 : 32'd0;
        3'b110, 3'b111: res = (rs1 < rs2) ? 32'd1 : 32'd0;
        default: bad = 1'b1;
      endcase
      // branch condition straight from the ISA definition
      case (f3)
        3'b000:  taken = (rs1 == rs2);
        3'b001:  taken = (rs1 != rs2);
        3'b100:  taken = ($signed(rs1) < $signed(rs2));
        3'b101:  taken = ($signed(rs1) >= $signed(rs2));
        3'b110:  taken = (rs1 < rs2);
        3'b111:  taken = (rs1 >= rs2);
        default: taken = 1'b0;
      endcase
    end
    default: bad = 1'b1;
  endcase
  npc = taken ? pc + imm_b : pc + 32'd4;
  status = 32'b0;
  status[exec_regs_pkg::STATUS_BRANCH_TAKEN] = taken;
  status[exec_regs_pkg::STATUS_ILLEGAL]      = bad;
  return {res, npc, status};
endfunction

`endif

// File: tb/tb_exec_unit.sv
// testbench for the RV32I execute unit
// clock, reset, Wishbone tasks, check task, watchdog and test sequence

`timescale 1ns/1ps

module tb_exec_unit;

  localparam int CLK_PERIOD = 10;
  // reset block plus up to 7 bus cycles per instruction
  localparam int N_INSTR = 40 + 36 + 32 + 42 + 7 + 200;
  localparam int N_TRANS = 12 + N_INSTR * 7;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  integer      seed;

  `include "exec_model.svh"

  exec_unit i_exec_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // ack sampled at the falling edge, away from the DUT update
  task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                           output logic [31:0] rd);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    do @(negedge clk); while (!wb_ack);
    rd = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'b0, dat);
  endtask

  task automatic run_instr(input string name, input logic [31:0] ins, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] p, input bit status_only);
    logic [95:0] exp;
    logic [31:0] rd;
    exp = exec_ref(ins, a, b, p);
    wb_write(exec_regs_pkg::REG_INSTR, ins);
    wb_write(exec_regs_pkg::REG_RS1, a);
    wb_write(exec_regs_pkg::REG_RS2, b);
    wb_write(exec_regs_pkg::REG_PC, p);
    wb_read(exec_regs_pkg::REG_STATUS, rd);
    check({name, " status"}, exp[31:0], rd);
    if (!status_only) begin
      wb_read(exec_regs_pkg::REG_RESULT, rd);
      check({name, " result"}, exp[95:64], rd);
      wb_read(exec_regs_pkg::REG_NEXT_PC, rd);
      check({name, " next_pc"}, exp[63:32], rd);
    end
  endtask

  // random word with opcode, funct3 and optionally funct7 forced
  function automatic logic [31:0] encode(input logic [6:0] opc, input logic [2:0] f3,
                                         input bit set_f7, input logic [6:0] f7);
    logic [31:0] w;
    w = $random(seed);
    w[6:0]   = opc;
    w[14:12] = f3;
    if (set_f7)
      w[31:25] = f7;
    return w;
  endfunction

  function automatic logic [31:0] rand_legal();
    logic [31:0] w;
    logic [2:0]  f3;
    f3 = $random(seed);
    case ($unsigned($random(seed)) % 7)
      0: w = encode(rv_constants_pkg::OPCODE_OP, f3, 1'b1,
                    ((f3 == 3'b000 || f3 == 3'b101) && seed[3]) ? 7'h20 : 7'h00);
      1: w = encode(rv_constants_pkg::OPCODE_OP_IMM, f3, f3[1:0] == 2'b01,
                    (f3 == 3'b101 && seed[5]) ? 7'h20 : 7'h00);
      2: w = encode(rv_constants_pkg::OPCODE_LUI, f3, 1'b0, 7'h00);
      3: w = encode(rv_constants_pkg::OPCODE_AUIPC, f3, 1'b0, 7'h00);
      4: w = encode(rv_constants_pkg::OPCODE_LOAD, f3, 1'b0, 7'h00);
      5: w = encode(rv_constants_pkg::OPCODE_STORE, f3, 1'b0, 7'h00);
      default: w = encode(rv_constants_pkg::OPCODE_BRANCH,
                          (f3[2:1] == 2'b01) ? 3'b000 : f3, 1'b0, 7'h00);
    endcase
    return w;
  endfunction

  // bus hang guard
  initial begin
    #(N_TRANS * 20 * CLK_PERIOD);
    $display("Timeout: the bus never acknowledged a transfer");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  br_f3 [6];
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 5'b0;
    wb_dat_w    = 32'b0;
    seed        = 32'h516c_7f4b;
    br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // reset state, unmapped offset, read-only write
    for (int i = 0; i < 4; i++) begin
      wb_read(5'(i * 4), rd);
      check("reset register", 32'b0, rd);
    end
    wb_read(exec_regs_pkg::REG_STATUS, rd);
    check("reset status", 32'h2, rd);
    wb_read(5'h1C, rd);
    check("unmapped read", 32'b0, rd);
    // all operands still zero, so the result stays zero
    wb_write(exec_regs_pkg::REG_RESULT, 32'hdead_beef);
    wb_read(exec_regs_pkg::REG_RESULT, rd);
    check("result write ignored", 32'b0, rd);

    // OP with both funct7 variants, OP_IMM with SRAI
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          repeat (4) begin
            ins = encode(rv_constants_pkg::OPCODE_OP, 3'(f), 1'b1, alt ? 7'h20 : 7'h00);
            run_instr("op", ins, $random(seed), $random(seed), $random(seed) & ~32'h3, 0);
          end
          if (alt == 0 || f == 5) begin
            repeat (4) begin
              ins = encode(rv_constants_pkg::OPCODE_OP_IMM, 3'(f), f == 1 || f == 5,
                           alt ? 7'h20 : 7'h00);
              run_instr("op_imm", ins, $random(seed), $random(seed), $random(seed), 0);
            end
          end
        end
      end
    end

    // upper immediates and address computation
    repeat (8) begin
      run_instr("lui", encode(rv_constants_pkg::OPCODE_LUI, 3'($random(seed)), 0, 0),
                $random(seed), $random(seed), $random(seed), 0);
      run_instr("auipc", encode(rv_constants_pkg::OPCODE_AUIPC, 3'($random(seed)), 0, 0),
                $random(seed), $random(seed), $random(seed), 0);
      run_instr("load", encode(rv_constants_pkg::OPCODE_LOAD, 3'($random(seed)), 0, 0),
                $random(seed), $random(seed), $random(seed), 0);
      run_instr("store", encode(rv_constants_pkg::OPCODE_STORE, 3'($random(seed)), 0, 0),
                $random(seed), $random(seed), $random(seed), 0);
    end

    // branches: random, equal and sign boundary operands
    for (int f = 0; f < 6; f++) begin
      for (int k = 0; k < 7; k++) begin
        ins = encode(rv_constants_pkg::OPCODE_BRANCH, br_f3[f], 0, 0);
        a = $random(seed);
        b = $random(seed);
        if (k == 4)
          b = a;
        if (k == 5) begin
          a = 32'h8000_0000;
          b = 32'h7fff_ffff;
        end
        if (k == 6) begin
          a = 32'h7fff_ffff;
          b = 32'h8000_0000;
        end
        run_instr("branch", ins, a, b, $random(seed) & ~32'h3, 0);
      end
    end

    // illegal encodings
    run_instr("bad opcode 7f", encode(7'h7f, 3'b000, 0, 0), 1, 2, 0, 1);
    run_instr("bad opcode 00", encode(7'h00, 3'b000, 0, 0), 1, 2, 0, 1);
    run_instr("bad opcode jal", encode(7'h6f, 3'b000, 0, 0), 1, 2, 0, 1);
    run_instr("branch f3 010", encode(rv_constants_pkg::OPCODE_BRANCH, 3'b010, 0, 0),
              5, 5, 32'h100, 1);
    run_instr("branch f3 011", encode(rv_constants_pkg::OPCODE_BRANCH, 3'b011, 0, 0),
              5, 5, 32'h100, 1);
    run_instr("op funct7 01", encode(rv_constants_pkg::OPCODE_OP, 3'b000, 1, 7'h01),
              1, 2, 0, 1);
    run_instr("op sll funct7 20", encode(rv_constants_pkg::OPCODE_OP, 3'b001, 1, 7'h20),
              1, 2, 0, 1);

    // random mix of legal instructions
    repeat (200) begin
      run_instr("random", rand_legal(), $random(seed), $random(seed),
                $random(seed) & ~32'h3, 0);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule
